// ==== common/icache_geom_pkg.sv ====
// geometry is fixed at 2 ways x 256 sets x 4 words; other sizes need new field widths below
`default_nettype none

package icache_geom_pkg;

    ////////////////////
    // address fields
    ////////////////////
    localparam int addr_w         = 30;   // fetch word address
    localparam int tag_w          = 20;   // addr[29:10]
    localparam int index_w        = 8;    // addr[9:2]
    localparam int num_sets       = 256;
    localparam int word_sel_w     = 2;    // addr[1:0]

    ////////////////////
    // line and entry
    ////////////////////
    localparam int words_per_line = 4;
    localparam int word_w         = 32;
    localparam int line_w         = 128;
    localparam int thread_w       = 2;    // four hardware threads
    localparam int num_ways       = 2;

    // word k sits at bits k*32+31 : k*32
    typedef logic [words_per_line-1:0][word_w-1:0] line_t;

    // one stored way entry, 151 bits
    typedef struct packed {
        logic                valid;
        logic [thread_w-1:0] thread;  // owner of the line
        logic [tag_w-1:0]    tag;
        line_t               line;
    } way_entry_t;

endpackage

`default_nettype wire

// ==== common/icache_bus_pkg.sv ====
// fetch and L2 ports are single-cycle strobes with no back-pressure
`default_nettype none

package icache_bus_pkg;

    ////////////////////
    // fetch side
    ////////////////////
    typedef struct packed {
        logic [icache_geom_pkg::thread_w-1:0] thread;
        logic [icache_geom_pkg::addr_w-1:0]   addr;    // word address
    } fetch_req_t;                                     // 32 bits

    typedef struct packed {
        logic [icache_geom_pkg::word_w-1:0]   word;
        logic [icache_geom_pkg::thread_w-1:0] thread;
        logic                                 refill;  // 1 = came from L2, 0 = hit
    } fetch_resp_t;                                    // 35 bits

    ////////////////////
    // L2 side
    ////////////////////
    typedef struct packed {
        logic [icache_geom_pkg::thread_w-1:0] thread;
        // tag plus index
        logic [icache_geom_pkg::tag_w+icache_geom_pkg::index_w-1:0] line_addr;
    } l2_req_t;                                        // 30 bits

    typedef struct packed {
        logic [icache_geom_pkg::thread_w-1:0] thread;
        icache_geom_pkg::line_t               line;
    } l2_resp_t;                                       // 130 bits

    ////////////////////
    // controller FSM
    ////////////////////
    typedef enum logic [1:0] {
        st_idle      = 2'd0,  // waiting for a fetch
        st_lookup    = 2'd1,  // tag compare on registered way data
        st_miss_wait = 2'd2,  // L2 request sent, waiting for our thread
        st_refill    = 2'd3   // line written, word goes out
    } ic_state_e;

endpackage

`default_nettype wire

// ==== icache/icache_way_array.sv ====
// read data is registered; a write and read to the same set in one cycle returns the new entry
`timescale 1ns/1ps
`default_nettype none

module icache_way_array (
    input  wire logic                               clk,
    input  wire logic                               reset,
    input  wire logic [icache_geom_pkg::index_w-1:0] rd_index,
    output icache_geom_pkg::way_entry_t             rd_entry,
    input  wire logic                               wr_en,
    input  wire logic [icache_geom_pkg::index_w-1:0] wr_index,
    input  wire icache_geom_pkg::way_entry_t        wr_entry
);

    ////////////////////
    // storage
    ////////////////////
    logic [icache_geom_pkg::thread_w-1:0] thread_mem [icache_geom_pkg::num_sets];
    logic [icache_geom_pkg::tag_w-1:0]    tag_mem    [icache_geom_pkg::num_sets];
    icache_geom_pkg::line_t               line_mem   [icache_geom_pkg::num_sets];
    logic [icache_geom_pkg::num_sets-1:0] valid_q;                 // cleared by reset

    logic                                 bypass;                  // same-set write
    logic                                 rd_valid_q;
    logic [icache_geom_pkg::thread_w-1:0] rd_thread_q;
    logic [icache_geom_pkg::tag_w-1:0]    rd_tag_q;
    icache_geom_pkg::line_t               rd_line_q;

    assign bypass = wr_en && (wr_index == rd_index);

    // valid bits carry the reset
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            if (wr_en) begin
                valid_q[wr_index] <= wr_entry.valid;
            end
            rd_valid_q <= bypass ? wr_entry.valid : valid_q[rd_index];
        end
    end

    // tag, thread and data memories
    always_ff @(posedge clk) begin
        if (wr_en) begin
            thread_mem[wr_index] <= wr_entry.thread;
            tag_mem[wr_index]    <= wr_entry.tag;
            line_mem[wr_index]   <= wr_entry.line;
        end
        if (bypass) begin
            rd_thread_q <= wr_entry.thread;
            rd_tag_q    <= wr_entry.tag;
            rd_line_q   <= wr_entry.line;
        end else begin
            rd_thread_q <= thread_mem[rd_index];
            rd_tag_q    <= tag_mem[rd_index];
            rd_line_q   <= line_mem[rd_index];
        end
    end

    assign rd_entry.valid  = rd_valid_q;
    assign rd_entry.thread = rd_thread_q;
    assign rd_entry.tag    = rd_tag_q;
    assign rd_entry.line   = rd_line_q;

endmodule

`default_nettype wire

// ==== icache/icache_replace.sv ====
// two ways only; victim is combinational from the current index and valid bits
`timescale 1ns/1ps
`default_nettype none

module icache_replace (
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  wire logic [icache_geom_pkg::index_w-1:0] index,
    input  wire logic [icache_geom_pkg::num_ways-1:0] valid_bits,
    output logic                                     victim_way,
    input  wire logic                                touch,
    input  wire logic                                touch_way
);

    // one bit per set naming the way to evict next
    logic [icache_geom_pkg::num_sets-1:0] lru_q;

    ////////////////////
    // victim select
    ////////////////////
    always_comb begin
        if (!valid_bits[0]) begin
            victim_way = 1'b0;                                     // empty way 0 first
        end else if (!valid_bits[1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_q[index];                             // both full
        end
    end

    ////////////////////
    // LRU update
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q <= '0;
        end else if (touch) begin
            lru_q[index] <= ~touch_way;                            // point at the other way
        end
    end

endmodule

`default_nettype wire

// ==== icache/icache_ctrl.sv ====
// one fetch in flight at a time; strobes while busy are dropped, L2 replies for other threads ignored
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
    input  wire logic                                  clk,
    input  wire logic                                  reset,
    input  wire logic                                  fetch_valid,
    input  wire icache_bus_pkg::fetch_req_t            fetch_req,
    output logic                                       resp_valid,
    output icache_bus_pkg::fetch_resp_t                resp,
    output logic                                       busy,
    output logic                                       l2_req_valid,
    output icache_bus_pkg::l2_req_t                    l2_req,
    input  wire logic                                  l2_resp_valid,
    input  wire icache_bus_pkg::l2_resp_t              l2_resp,
    output logic [icache_geom_pkg::index_w-1:0]        rd_index,
    input  wire icache_geom_pkg::way_entry_t           way0_entry,
    input  wire icache_geom_pkg::way_entry_t           way1_entry,
    output logic                                       wr_en0,
    output logic                                       wr_en1,
    output logic [icache_geom_pkg::index_w-1:0]        wr_index,
    output icache_geom_pkg::way_entry_t                wr_entry,
    input  wire logic                                  victim_way,
    output logic                                       touch,
    output logic                                       touch_way,
    output logic [icache_geom_pkg::num_ways-1:0]       valid_bits
);

    icache_bus_pkg::ic_state_e                  state_q;
    icache_bus_pkg::ic_state_e                  state_d;
    icache_bus_pkg::fetch_req_t                 req_q;        // latched fetch
    icache_geom_pkg::line_t                     refill_line_q;

    logic [icache_geom_pkg::tag_w-1:0]          tag_q;
    logic [icache_geom_pkg::index_w-1:0]        index_q;
    logic [icache_geom_pkg::word_sel_w-1:0]     sel_q;
    logic                                       accept;       // fetch taken this cycle
    logic                                       hit0;
    logic                                       hit1;
    logic                                       hit;
    logic                                       refill_ok;    // L2 reply for our thread
    icache_geom_pkg::line_t                     hit_line;

    ////////////////////
    // address fields
    ////////////////////
    assign tag_q   = req_q.addr[icache_geom_pkg::addr_w-1 -: icache_geom_pkg::tag_w];
    assign index_q = req_q.addr[icache_geom_pkg::word_sel_w +: icache_geom_pkg::index_w];
    assign sel_q   = req_q.addr[icache_geom_pkg::word_sel_w-1:0];

    assign accept  = fetch_valid && (state_q == icache_bus_pkg::st_idle);

    // arrays follow the incoming fetch while idle, then hold on the latched set
    assign rd_index = (state_q == icache_bus_pkg::st_idle) ?
                      fetch_req.addr[icache_geom_pkg::word_sel_w +: icache_geom_pkg::index_w] :
                      index_q;

    ////////////////////
    // tag compare
    ////////////////////
    // thread id is part of the match
    assign hit0 = way0_entry.valid && (way0_entry.thread == req_q.thread) &&
                  (way0_entry.tag == tag_q);
    assign hit1 = way1_entry.valid && (way1_entry.thread == req_q.thread) &&
                  (way1_entry.tag == tag_q);
    assign hit  = hit0 || hit1;

    assign hit_line   = hit1 ? way1_entry.line : way0_entry.line;
    assign valid_bits = {way1_entry.valid, way0_entry.valid};

    assign refill_ok = (state_q == icache_bus_pkg::st_miss_wait) && l2_resp_valid &&
                       (l2_resp.thread == req_q.thread);

    ////////////////////
    // FSM
    ////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_bus_pkg::st_idle: begin
                if (fetch_valid) begin
                    state_d = icache_bus_pkg::st_lookup;
                end
            end
            icache_bus_pkg::st_lookup: begin
                state_d = hit ? icache_bus_pkg::st_idle : icache_bus_pkg::st_miss_wait;
            end
            icache_bus_pkg::st_miss_wait: begin
                if (refill_ok) begin
                    state_d = icache_bus_pkg::st_refill;
                end
            end
            default: begin                                         // st_refill
                state_d = icache_bus_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= icache_bus_pkg::st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= fetch_req;
        end
        if (refill_ok) begin
            refill_line_q <= l2_resp.line;                         // word for next cycle
        end
    end

    ////////////////////
    // outputs
    ////////////////////
    assign busy = (state_q != icache_bus_pkg::st_idle);

    assign resp_valid  = ((state_q == icache_bus_pkg::st_lookup) && hit) ||
                         (state_q == icache_bus_pkg::st_refill);
    assign resp.word   = (state_q == icache_bus_pkg::st_refill) ? refill_line_q[sel_q] :
                                                                  hit_line[sel_q];
    assign resp.thread = req_q.thread;
    assign resp.refill = (state_q == icache_bus_pkg::st_refill);

    assign l2_req_valid     = (state_q == icache_bus_pkg::st_lookup) && !hit;  // one per miss
    assign l2_req.thread    = req_q.thread;
    assign l2_req.line_addr = req_q.addr[icache_geom_pkg::addr_w-1:icache_geom_pkg::word_sel_w];

    // refill goes into the victim way in the same cycle the reply lands
    assign wr_en0          = refill_ok && !victim_way;
    assign wr_en1          = refill_ok && victim_way;
    assign wr_index        = index_q;
    assign wr_entry.valid  = 1'b1;
    assign wr_entry.thread = req_q.thread;
    assign wr_entry.tag    = tag_q;
    assign wr_entry.line   = l2_resp.line;

    assign touch     = ((state_q == icache_bus_pkg::st_lookup) && hit) || refill_ok;
    assign touch_way = refill_ok ? victim_way : hit1;

    ////////////////////
    // checks
    ////////////////////
    // the fetch stage must hold off while a fetch is in flight
    a_no_fetch_while_busy: assert property (@(posedge clk) disable iff (reset)
        busy |-> !fetch_valid);

    // a line is only ever filled into one way for a given thread and tag
    a_single_way_hit: assert property (@(posedge clk) disable iff (reset)
        (state_q == icache_bus_pkg::st_lookup) |-> !(hit0 && hit1));

    // L2 only answers while a miss is outstanding
    a_l2_resp_in_miss_wait: assert property (@(posedge clk) disable iff (reset)
        l2_resp_valid |-> (state_q == icache_bus_pkg::st_miss_wait));

endmodule

`default_nettype wire

// ==== verilog/icache_top.sv ====
// fetch strobes must not arrive while busy is high; there is no write or invalidate path
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     fetch_valid,
    input  wire icache_bus_pkg::fetch_req_t fetch_req,
    output logic                          resp_valid,
    output icache_bus_pkg::fetch_resp_t   resp,
    output logic                          busy,
    output logic                          l2_req_valid,
    output icache_bus_pkg::l2_req_t       l2_req,
    input  wire logic                     l2_resp_valid,
    input  wire icache_bus_pkg::l2_resp_t l2_resp
);

    logic [icache_geom_pkg::index_w-1:0]  rd_index;
    logic [icache_geom_pkg::index_w-1:0]  wr_index;              // latched lookup set
    icache_geom_pkg::way_entry_t          way0_entry;
    icache_geom_pkg::way_entry_t          way1_entry;
    icache_geom_pkg::way_entry_t          wr_entry;
    logic                                 wr_en0;
    logic                                 wr_en1;
    logic                                 victim_way;
    logic                                 touch;
    logic                                 touch_way;
    logic [icache_geom_pkg::num_ways-1:0] valid_bits;

    ////////////////////
    // controller
    ////////////////////
    icache_ctrl u_icache_ctrl (
        .clk           (clk),
        .reset         (reset),
        .fetch_valid   (fetch_valid),
        .fetch_req     (fetch_req),
        .resp_valid    (resp_valid),
        .resp          (resp),
        .busy          (busy),
        .l2_req_valid  (l2_req_valid),
        .l2_req        (l2_req),
        .l2_resp_valid (l2_resp_valid),
        .l2_resp       (l2_resp),
        .rd_index      (rd_index),
        .way0_entry    (way0_entry),
        .way1_entry    (way1_entry),
        .wr_en0        (wr_en0),
        .wr_en1        (wr_en1),
        .wr_index      (wr_index),
        .wr_entry      (wr_entry),
        .victim_way    (victim_way),
        .touch         (touch),
        .touch_way     (touch_way),
        .valid_bits    (valid_bits)
    );

    ////////////////////
    // ways
    ////////////////////
    icache_way_array u_way0 (
        .clk      (clk),
        .reset    (reset),
        .rd_index (rd_index),
        .rd_entry (way0_entry),
        .wr_en    (wr_en0),
        .wr_index (wr_index),
        .wr_entry (wr_entry)
    );

    icache_way_array u_way1 (
        .clk      (clk),
        .reset    (reset),
        .rd_index (rd_index),
        .rd_entry (way1_entry),
        .wr_en    (wr_en1),
        .wr_index (wr_index),
        .wr_entry (wr_entry)
    );

    // LRU works on the held set, which matches the registered way data
    icache_replace u_icache_replace (
        .clk        (clk),
        .reset      (reset),
        .index      (wr_index),
        .valid_bits (valid_bits),
        .victim_way (victim_way),
        .touch      (touch),
        .touch_way  (touch_way)
    );

endmodule

`default_nettype wire

// ==== tb/tb_icache.sv ====
// run from the project root so tb/icache_input.txt opens; only one fetch is in flight at a time
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

    logic                        clk;
    logic                        reset;
    logic                        fetch_valid;
    icache_bus_pkg::fetch_req_t  fetch_req;
    logic                        resp_valid;
    icache_bus_pkg::fetch_resp_t resp;
    logic                        busy;
    logic                        l2_req_valid;
    icache_bus_pkg::l2_req_t     l2_req;
    logic                        l2_resp_valid;
    icache_bus_pkg::l2_resp_t    l2_resp;

    int unsigned wait_limit = 50;                                  // cycles per handshake wait
    int          error_count;
    int          tests_ok;
    int          tests_bad;
    bit          timeout_seen;
    bit          setup_error;

    icache_top u_icache_top (
        .clk           (clk),
        .reset         (reset),
        .fetch_valid   (fetch_valid),
        .fetch_req     (fetch_req),
        .resp_valid    (resp_valid),
        .resp          (resp),
        .busy          (busy),
        .l2_req_valid  (l2_req_valid),
        .l2_req        (l2_req),
        .l2_resp_valid (l2_resp_valid),
        .l2_resp       (l2_resp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                                     // 4 ns period
    end

    ////////////////////
    // helpers
    ////////////////////
    task automatic next_cycle();
        @(posedge clk);
        #1;                                                        // drive and sample point
    endtask

    task automatic compare_value(input string name, input string what,
                                 input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("CHECK FAILED %s %s: expected %08h, actual %08h", name, what, exp, got);
            error_count++;
        end
    endtask

    // word k of line A is {thread, A*4+k}
    function automatic icache_geom_pkg::line_t build_line(input logic [1:0] thread,
                                                          input logic [27:0] line_addr);
        icache_geom_pkg::line_t line;
        for (int k = 0; k < icache_geom_pkg::words_per_line; k++) begin
            line[k] = {thread, line_addr, 2'(k)};
        end
        return line;
    endfunction

    task automatic wait_for_req_or_resp(input string name, output bit ok);
        int unsigned cycles;
        cycles = 0;
        while (!l2_req_valid && !resp_valid && cycles < wait_limit) begin
            next_cycle();
            cycles++;
        end
        ok = l2_req_valid || resp_valid;
        if (!ok) begin
            $display("%s: neither an L2 request nor a response came within %0d cycles",
                     name, wait_limit);
        end
    endtask

    task automatic wait_for_resp(input string name, output bit ok);
        int unsigned cycles;
        cycles = 0;
        while (!resp_valid && cycles < wait_limit) begin
            compare_value(name, "l2_req_valid", 32'd0, l2_req_valid);  // one request per miss
            next_cycle();
            cycles++;
        end
        ok = resp_valid;
        if (!ok) begin
            $display("%s: no response within %0d cycles after the refill", name, wait_limit);
        end
    endtask

    task automatic send_refill(input logic [1:0] thread, input logic [27:0] line_addr);
        next_cycle();
        l2_resp_valid  = 1'b1;
        l2_resp.thread = thread;
        l2_resp.line   = build_line(thread, line_addr);
        next_cycle();
        l2_resp_valid  = 1'b0;
    endtask

    task automatic check_reset_idle();
        int errors_before;
        errors_before = error_count;
        repeat (4) begin
            next_cycle();
            compare_value("reset_idle", "resp_valid", 32'd0, resp_valid);
            compare_value("reset_idle", "l2_req_valid", 32'd0, l2_req_valid);
            compare_value("reset_idle", "busy", 32'd0, busy);
        end
        if (error_count == errors_before) begin
            tests_ok++;
        end else begin
            tests_bad++;
        end
        $display("reset_idle: %s", (error_count == errors_before) ? "ok" : "mismatch");
    endtask

    ////////////////////
    // one fetch
    ////////////////////
    task automatic run_fetch(input int test_num, input logic [1:0] thread,
                             input logic [29:0] addr, input int delay, input logic wrong,
                             input logic [31:0] exp_word, input logic exp_refill);
        string       name;
        bit          ok;
        bit          saw_req;
        int          errors_before;
        logic [27:0] line_addr;
        name          = $sformatf("fetch_%0d", test_num);
        errors_before = error_count;
        saw_req       = 1'b0;
        line_addr     = addr[29:2];
        repeat ($urandom % 4) next_cycle();                        // idle gap
        next_cycle();
        fetch_valid      = 1'b1;
        fetch_req.thread = thread;
        fetch_req.addr   = addr;
        next_cycle();
        fetch_valid = 1'b0;
        wait_for_req_or_resp(name, ok);
        if (ok && l2_req_valid) begin
            saw_req = 1'b1;
            compare_value(name, "l2_req.thread", thread, l2_req.thread);
            compare_value(name, "l2_req.line_addr", line_addr, l2_req.line_addr);
            if (wrong) begin
                send_refill(thread ^ 2'd1, line_addr);             // must be ignored
                compare_value(name, "resp_valid after wrong thread", 32'd0, resp_valid);
            end
            repeat (delay) begin
                next_cycle();
                compare_value(name, "resp_valid while waiting", 32'd0, resp_valid);
                compare_value(name, "l2_req_valid while waiting", 32'd0, l2_req_valid);
            end
            send_refill(thread, line_addr);
            wait_for_resp(name, ok);
        end
        if (!ok) begin
            timeout_seen = 1'b1;
            tests_bad++;
            return;
        end
        compare_value(name, "l2 request issued", exp_refill, saw_req);
        compare_value(name, "resp.word", exp_word, resp.word);
        compare_value(name, "resp.refill", exp_refill, resp.refill);
        compare_value(name, "resp.thread", thread, resp.thread);
        compare_value(name, "busy", 32'd1, busy);
        if (error_count == errors_before) begin
            tests_ok++;
        end else begin
            tests_bad++;
        end
        $display("%s thread %0d addr %08h %s: %s", name, thread, addr,
                 exp_refill ? "refill" : "hit",
                 (error_count == errors_before) ? "ok" : "mismatch");
    endtask

    ////////////////////
    // main sequence
    ////////////////////
    initial begin
        int unsigned seed;
        int unsigned discard;
        int          fd;
        int          read_len;
        int          fields;
        int          test_num;
        string       line_s;
        logic [1:0]  f_thread;
        logic [29:0] f_addr;
        int          f_delay;
        logic        f_wrong;
        logic [31:0] f_word;
        logic        f_refill;
        reset         = 1'b1;
        fetch_valid   = 1'b0;
        fetch_req     = '0;
        l2_resp_valid = 1'b0;
        l2_resp       = '0;
        error_count   = 0;
        tests_ok      = 0;
        tests_bad     = 0;
        timeout_seen  = 1'b0;
        setup_error   = 1'b0;
        test_num      = 0;
        seed          = 32'h8fbb_4218;
        discard       = $urandom(seed);
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        fd = $fopen("tb/icache_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/icache_input.txt");
            setup_error = 1'b1;
        end else begin
            check_reset_idle();
            while (!$feof(fd) && !timeout_seen) begin
                read_len = $fgets(line_s, fd);
                if (read_len > 0 && line_s.len() > 1 && line_s.substr(0, 0) != "#") begin
                    fields = $sscanf(line_s, "%h %h %d %h %h %h", f_thread, f_addr, f_delay,
                                     f_wrong, f_word, f_refill);
                    if (fields == 6) begin
                        test_num++;
                        run_fetch(test_num, f_thread, f_addr, f_delay, f_wrong, f_word,
                                  f_refill);
                    end else begin
                        $display("unreadable line in input file: %s", line_s);
                        setup_error = 1'b1;
                    end
                end
            end
            $fclose(fd);
        end
        repeat (2) next_cycle();
        $display("tests %0d, ok %0d, mismatching %0d, check errors %0d",
                 tests_ok + tests_bad, tests_ok, tests_bad, error_count);
        if (error_count == 0 && !timeout_seen && !setup_error && test_num > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/icache_geom_pkg.sv
common/icache_bus_pkg.sv
icache/icache_way_array.sv
icache/icache_replace.sv
icache/icache_ctrl.sv
verilog/icache_top.sv
tb/tb_icache.sv

// ==== tb/icache_input.txt ====
# thread(hex) addr(hex, 30-bit word address) l2_delay(dec) wrong_thread_first(0/1)
# expected_word(hex) expected_refill(0/1)
# cold miss on set 10, then hits at other word selects
0 00000441 0 0 00000441 1
0 00000443 0 0 00000443 0
0 00000440 0 0 00000440 0
# same address, other thread
1 00000441 2 0 40000441 1
1 00000442 0 0 40000442 0
0 00000441 0 0 00000441 0
# three tags into set 20 for thread 2
2 00004081 1 0 80004081 1
2 00008082 0 0 80008082 1
2 00004083 0 0 80004083 0
2 0000c080 2 0 8000c080 1
2 00004080 0 0 80004080 0
2 00008081 0 0 80008081 1
2 00004082 0 0 80004082 0
# wrong-thread L2 response before the real refill
3 2af3796a 3 1 eaf3796a 1
3 2af37969 0 0 eaf37969 0
0 2af37969 1 1 2af37969 1
# ownership kept across sets
1 00000441 0 0 40000441 0
# top of the address space
3 3fffffff 4 0 ffffffff 1
3 3ffffffc 0 0 fffffffc 0
2 00008083 0 0 80008083 0
